//--- include/kbd_macros.svh
`ifndef KBD_MACROS_SVH
`define KBD_MACROS_SVH

// keyboard byte and line handling
`define KBD_BYTE_W 8
`define KBD_SYNC_STAGES 2

// latch cycles with the keyboard clock held low before a host frame
`define KBD_INHIBIT_CYCLES 8

// select scan code set, its argument, and the keyboard acknowledge
`define KBD_CMD_SET_CODES 8'hf0
`define KBD_CODE_SET_1 8'h01
`define KBD_ACK 8'hfa

`endif

//--- logic/kbd_pkg.sv
`default_nettype none

`include "kbd_macros.svh"

package kbd_pkg;

	typedef logic [`KBD_BYTE_W-1:0] kbd_byte_t; // one keyboard byte

	typedef enum logic [2:0] {
		SEND_CMD, // offer F0 to the transmitter
		WAIT_CMD_DONE,
		WAIT_CMD_ACK,
		SEND_ARG, // offer 01
		WAIT_ARG_DONE,
		WAIT_ARG_ACK,
		IDLE, // initialised, waiting for a scan code
		HOLD // scan code on pa, irq1 high
	} ctrl_state_e;

	typedef enum logic [2:0] {
		READY,
		INHIBIT, // clock pulled low
		REQUEST, // data low, clock released
		SHIFT,
		STOP
	} tx_state_e;

endpackage

`default_nettype wire

//--- logic/kbd_line_if.sv
`default_nettype none

interface kbd_line_if;

	logic clock_fall; // one-cycle pulse per falling keyboard clock
	logic clock_rise; // one-cycle pulse per rising keyboard clock
	logic data_bit; // synchronised data level
	logic clock_level; // synchronised clock level

	modport source (
		output clock_fall, clock_rise, data_bit, clock_level
	);

	modport sink (
		input clock_fall, clock_rise, data_bit, clock_level
	);

endinterface

`default_nettype wire

//--- logic/kbd_line_sync.sv
`default_nettype none

`include "kbd_macros.svh"

module kbd_line_sync (
	input  logic       latch,
	input  logic       reset,
	input  logic       kbd_clock,
	input  logic       kbd_data,
	kbd_line_if.source line
);

	localparam int S = `KBD_SYNC_STAGES;

	// top stage holds the previous settled level for edge detection
	logic [S:0] clock_sync;
	logic [S:0] data_sync;

	always_ff @(posedge latch) begin
		if (reset) begin
			clock_sync <= '1; // idle high, no false edge
			data_sync <= '1;
			line.clock_fall <= 1'b0;
			line.clock_rise <= 1'b0;
		end else begin
			clock_sync <= {clock_sync[S-1:0], kbd_clock};
			data_sync <= {data_sync[S-1:0], kbd_data};
			line.clock_fall <= clock_sync[S] & ~clock_sync[S-1];
			line.clock_rise <= ~clock_sync[S] & clock_sync[S-1];
		end
	end

	// levels aligned with the registered edge pulses
	assign line.data_bit = data_sync[S];
	assign line.clock_level = clock_sync[S];

endmodule

`default_nettype wire

//--- logic/kbd_frame_rx.sv
`default_nettype none

`include "kbd_macros.svh"

module kbd_frame_rx (
	input  logic               latch,
	input  logic               reset,
	kbd_line_if.sink           line,
	input  logic               tx_busy,
	output logic               rx_valid,
	output kbd_pkg::kbd_byte_t rx_byte
);

	import kbd_pkg::*;

	localparam int FRAME_BITS = `KBD_BYTE_W + 3; // start, data, parity, stop
	localparam logic [3:0] LAST_BIT = 4'(FRAME_BITS - 1);
	localparam logic [3:0] DATA_END = 4'(`KBD_BYTE_W);

	logic [3:0] bit_cnt; // index of the next bit in the frame
	kbd_byte_t shift_q;

	always_ff @(posedge latch) begin
		if (reset || tx_busy) begin
			bit_cnt <= '0; // host frame on the wire, not ours
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (line.clock_fall) begin
				if (bit_cnt == LAST_BIT) begin
					bit_cnt <= '0;
					rx_valid <= 1'b1; // stop bit seen
				end else if (bit_cnt != '0 || !line.data_bit) begin
					bit_cnt <= bit_cnt + 4'd1; // start bit must be low
				end
			end
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge latch) begin
		if (line.clock_fall && bit_cnt >= 4'd1 && bit_cnt <= DATA_END) begin
			shift_q <= {line.data_bit, shift_q[`KBD_BYTE_W-1:1]};
		end
	end

	assign rx_byte = shift_q; // stable from bit 8 until the next frame

endmodule

`default_nettype wire

//--- logic/kbd_frame_tx.sv
`default_nettype none

`include "kbd_macros.svh"

module kbd_frame_tx (
	input  logic               latch,
	input  logic               reset,
	kbd_line_if.sink           line,
	input  logic               tx_start,
	input  kbd_pkg::kbd_byte_t tx_byte,
	output logic               tx_ready,
	output logic               kbd_clock_low,
	output logic               kbd_data_low
);

	import kbd_pkg::*;

	localparam logic [3:0] INHIBIT_LAST = 4'(`KBD_INHIBIT_CYCLES - 1);
	localparam logic [3:0] PARITY_IDX = 4'(`KBD_BYTE_W);

	tx_state_e state;
	kbd_byte_t byte_q; // byte being sent
	logic [3:0] count; // inhibit cycles, then bit index
	logic cur_bit; // level presented on the data line
	logic parity;

	assign parity = ~^byte_q; // odd parity over data plus parity bit
	assign tx_ready = (state == READY);
	assign kbd_clock_low = (state == INHIBIT);
	assign kbd_data_low = ~cur_bit;

	always_ff @(posedge latch) begin
		if (tx_start && state == READY) begin
			byte_q <= tx_byte;
		end
	end

	always_ff @(posedge latch) begin
		if (reset) begin
			state <= READY;
			count <= '0;
			cur_bit <= 1'b1;
		end else begin
			case (state)
				READY: begin
					count <= '0;
					if (tx_start) begin
						state <= INHIBIT;
					end
				end
				INHIBIT: begin
					if (!line.clock_level) begin // time the hold from the line seen low
						if (count == INHIBIT_LAST) begin
							state <= REQUEST;
							count <= '0;
							cur_bit <= 1'b0; // start bit
						end else begin
							count <= count + 4'd1;
						end
					end
				end
				REQUEST: begin
					if (line.clock_rise) begin // released clock now high
						state <= SHIFT;
					end
				end
				SHIFT: begin
					if (line.clock_fall) begin
						count <= count + 4'd1;
						if (count < PARITY_IDX) begin
							cur_bit <= byte_q[count[2:0]];
						end else if (count == PARITY_IDX) begin
							cur_bit <= parity;
						end else begin
							cur_bit <= 1'b1; // stop bit, line released
							state <= STOP;
						end
					end
				end
				STOP: begin
					if (line.clock_fall) begin
						state <= READY;
					end
				end
				default: state <= READY;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/kbd_ctrl.sv
`default_nettype none

`include "kbd_macros.svh"

module kbd_ctrl (
	input  logic               latch,
	input  logic               reset,
	input  logic               pb7,
	input  logic               rx_valid,
	input  kbd_pkg::kbd_byte_t rx_byte,
	input  logic               tx_ready,
	output logic               tx_start,
	output kbd_pkg::kbd_byte_t tx_byte,
	output kbd_pkg::kbd_byte_t pa,
	output logic               irq1
);

	import kbd_pkg::*;

	ctrl_state_e state;
	logic is_ack;

	assign is_ack = (rx_byte == `KBD_ACK);
	assign tx_start = (state == SEND_CMD) || (state == SEND_ARG);
	assign tx_byte = (state == SEND_ARG) ? `KBD_CODE_SET_1 : `KBD_CMD_SET_CODES;
	assign irq1 = (state == HOLD); // scan code waiting for the pc

	always_ff @(posedge latch) begin
		if (reset) begin
			state <= SEND_CMD;
			pa <= '0;
		end else begin
			case (state)
				SEND_CMD: begin
					if (tx_ready) begin // accepted this cycle
						state <= WAIT_CMD_DONE;
					end
				end
				WAIT_CMD_DONE: begin
					if (tx_ready) begin
						state <= WAIT_CMD_ACK;
					end
				end
				WAIT_CMD_ACK: begin
					if (rx_valid) begin
						state <= is_ack ? SEND_ARG : SEND_CMD;
					end
				end
				SEND_ARG: begin
					if (tx_ready) begin
						state <= WAIT_ARG_DONE;
					end
				end
				WAIT_ARG_DONE: begin
					if (tx_ready) begin
						state <= WAIT_ARG_ACK;
					end
				end
				WAIT_ARG_ACK: begin
					if (rx_valid) begin
						state <= is_ack ? IDLE : SEND_CMD; // any other reply restarts
					end
				end
				IDLE: begin
					if (rx_valid) begin
						pa <= rx_byte;
						state <= HOLD;
					end
				end
				HOLD: begin
					if (pb7) begin // clear strobe from the pc
						pa <= '0;
						state <= IDLE;
					end
				end
				default: state <= SEND_CMD;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/kbd_interface.sv
`default_nettype none

module kbd_interface (
	input  logic               latch,
	input  logic               reset,
	input  logic               pb7,
	input  logic               kbd_clock,
	input  logic               kbd_data,
	output kbd_pkg::kbd_byte_t pa,
	output logic               irq1,
	output logic               kbd_clock_low,
	output logic               kbd_data_low
);

	import kbd_pkg::*;

	kbd_line_if line ();

	logic rx_valid;
	kbd_byte_t rx_byte;
	logic tx_start;
	kbd_byte_t tx_byte;
	logic tx_ready;
	logic tx_busy;

	assign tx_busy = ~tx_ready; // receiver ignores our own frames

	kbd_line_sync u_sync (
		.latch(latch),
		.reset(reset),
		.kbd_clock(kbd_clock),
		.kbd_data(kbd_data),
		.line(line.source)
	);

	kbd_frame_rx u_rx (
		.latch(latch),
		.reset(reset),
		.line(line.sink),
		.tx_busy(tx_busy),
		.rx_valid(rx_valid),
		.rx_byte(rx_byte)
	);

	kbd_frame_tx u_tx (
		.latch(latch),
		.reset(reset),
		.line(line.sink),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.tx_ready(tx_ready),
		.kbd_clock_low(kbd_clock_low),
		.kbd_data_low(kbd_data_low)
	);

	kbd_ctrl u_ctrl (
		.latch(latch),
		.reset(reset),
		.pb7(pb7),
		.rx_valid(rx_valid),
		.rx_byte(rx_byte),
		.tx_ready(tx_ready),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.pa(pa),
		.irq1(irq1)
	);

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
	output logic latch,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		latch = 1'b0;
		forever #20 latch = ~latch; // 40 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (5) @(posedge latch);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

//--- tests/kbd_interface_sva.sv
`default_nettype none

module kbd_interface_sva (
	input logic       latch,
	input logic       reset,
	input logic       pb7,
	input logic [7:0] pa,
	input logic       irq1,
	input logic       kbd_clock_low,
	input logic       kbd_data_low
);

	timeunit 1ns;
	timeprecision 100ps;

	assert property (@(posedge latch) reset && $past(reset) |-> !irq1)
		else $error("irq1 high during reset");

	// pa moves only with a new scan code or the clear strobe
	assert property (@(posedge latch) disable iff (reset)
		pa != $past(pa) |-> $rose(irq1) || $past(pb7))
		else $error("pa changed without a scan code or pb7");

	assert property (@(posedge latch)
		reset && $past(reset) |-> !kbd_clock_low && !kbd_data_low)
		else $error("keyboard line pulled low during reset");

endmodule

bind kbd_interface kbd_interface_sva u_sva (
	.latch(latch),
	.reset(reset),
	.pb7(pb7),
	.pa(pa),
	.irq1(irq1),
	.kbd_clock_low(kbd_clock_low),
	.kbd_data_low(kbd_data_low)
);

`default_nettype wire

//--- tests/tb_kbd_interface.sv
`default_nettype none

`include "kbd_macros.svh"

module tb_kbd_interface;

	timeunit 1ns;
	timeprecision 100ps;

	logic latch;
	logic reset;
	logic pb7;
	logic dev_clock; // device drive, 1 releases the line
	logic dev_data;
	logic kbd_clock;
	logic kbd_data;
	logic [7:0] pa;
	logic irq1;
	logic kbd_clock_low;
	logic kbd_data_low;

	logic [7:0] model_pa;
	logic model_irq;
	logic [7:0] code;
	int check_seq = 0;
	int checked_seq = 0;
	int checks = 0;
	int errors = 0;

	assign kbd_clock = dev_clock & ~kbd_clock_low; // open-drain wired-AND
	assign kbd_data = dev_data & ~kbd_data_low;

	tb_clock_gen u_clk (
		.latch(latch),
		.reset(reset)
	);

	kbd_interface u_dut (
		.latch(latch),
		.reset(reset),
		.pb7(pb7),
		.kbd_clock(kbd_clock),
		.kbd_data(kbd_data),
		.pa(pa),
		.irq1(irq1),
		.kbd_clock_low(kbd_clock_low),
		.kbd_data_low(kbd_data_low)
	);

	// pa after one event, from pa and irq1 before it
	function automatic logic [7:0] expected_pa(input logic [7:0] prev_pa, input logic prev_irq,
			input logic got_code, input logic [7:0] new_code, input logic clear);
		if (clear)
			return 8'h00;
		if (got_code && !prev_irq)
			return new_code; // latched only while irq1 is low
		return prev_pa;
	endfunction

	task automatic record_event(input logic got_code, input logic [7:0] new_code,
			input logic clear);
		model_pa = expected_pa(model_pa, model_irq, got_code, new_code, clear);
		model_irq = clear ? 1'b0 : (model_irq | got_code);
		check_seq++;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge latch);
	endtask

	// device clocks in a host frame, 10 cycles per phase
	task automatic receive_host_frame(input logic [7:0] expect_byte);
		int n;
		logic [10:0] bits;
		logic start_bit;
		n = 0;
		while (!(kbd_clock && !kbd_data) && n < 4000) begin
			@(negedge latch);
			n++;
		end
		if (!(kbd_clock && !kbd_data)) begin
			errors++;
			$display("timeout: host never requested to send a frame");
			return;
		end
		@(posedge latch);
		wait_cycles(9);
		@(negedge latch);
		start_bit = kbd_data; // start bit still held before the first fall
		@(posedge latch);
		for (int i = 0; i < 11; i++) begin
			dev_clock <= 1'b0;
			wait_cycles(9);
			@(negedge latch);
			bits[i] = kbd_data; // host bit settled in the low phase
			@(posedge latch);
			dev_clock <= 1'b1;
			wait_cycles(10);
		end
		checks++;
		if (bits[7:0] !== expect_byte) begin
			errors++;
			$display("FAIL t=%0t host byte expected %h got %h", $time, expect_byte, bits[7:0]);
		end
		if (^bits[8:0] !== 1'b1) begin
			errors++;
			$display("host frame at %0t does not carry odd parity", $time);
		end
		if (start_bit !== 1'b0 || bits[9] !== 1'b1) begin
			errors++;
			$display("host frame at %0t has a wrong start or stop bit", $time);
		end
	endtask

	task automatic send_device_frame(input logic [7:0] value);
		logic [10:0] bits;
		bits = {1'b1, ~^value, value, 1'b0}; // stop, odd parity, data, start
		@(posedge latch);
		for (int i = 0; i < 11; i++) begin
			dev_data <= bits[i];
			wait_cycles(10);
			dev_clock <= 1'b0;
			wait_cycles(10);
			dev_clock <= 1'b1;
		end
		wait_cycles(10);
	endtask

	task automatic pulse_clear();
		@(posedge latch);
		pb7 <= 1'b1;
		@(posedge latch);
		pb7 <= 1'b0;
		wait_cycles(3);
		record_event(1'b0, 8'h00, 1'b1);
	endtask

	task automatic wait_init_done();
		int n;
		n = 0;
		while (u_dut.u_ctrl.state != kbd_pkg::IDLE && n < 200) begin
			@(negedge latch);
			n++;
		end
		if (u_dut.u_ctrl.state != kbd_pkg::IDLE) begin
			errors++;
			$display("timeout: initialisation never finished");
		end
	endtask

	// compares pa and irq1 with the model once an event has settled
	initial begin : compare_proc
		forever begin
			@(negedge latch);
			if (check_seq != checked_seq) begin
				checked_seq = check_seq;
				checks++;
				if (pa !== model_pa) begin
					errors++;
					$display("FAIL t=%0t pa expected %h got %h", $time, model_pa, pa);
				end
				if (irq1 !== model_irq) begin
					errors++;
					$display("FAIL t=%0t irq1 expected %b got %b", $time, model_irq, irq1);
				end
			end
		end
	end

	initial begin : stimulus
		int n;
		logic [7:0] first_code;
		pb7 = 1'b0;
		dev_clock = 1'b1;
		dev_data = 1'b1;
		model_pa = 8'h00;
		model_irq = 1'b0;
		void'($urandom(32'he448a420));
		@(negedge latch);
		checks++;
		if (kbd_clock_low !== 1'b0) begin
			errors++;
			$display("FAIL t=%0t kbd_clock_low expected 0 got %b", $time, kbd_clock_low);
		end
		n = 0;
		while (reset && n < 20) begin
			@(negedge latch);
			n++;
		end
		if (reset) begin
			errors++;
			$display("timeout: reset never released");
		end
		checks++;
		if (kbd_data_low !== 1'b0) begin
			errors++;
			$display("FAIL t=%0t kbd_data_low expected 0 got %b", $time, kbd_data_low);
		end
		record_event(1'b0, 8'h00, 1'b0); // all zero after reset

		receive_host_frame(`KBD_CMD_SET_CODES);
		send_device_frame(`KBD_ACK);
		receive_host_frame(`KBD_CODE_SET_1);
		send_device_frame(8'hfe); // wrong reply restarts at F0
		receive_host_frame(`KBD_CMD_SET_CODES);
		send_device_frame(8'hfe);
		receive_host_frame(`KBD_CMD_SET_CODES);
		send_device_frame(`KBD_ACK);
		receive_host_frame(`KBD_CODE_SET_1);
		send_device_frame(`KBD_ACK);
		wait_init_done();

		first_code = 8'($urandom());
		send_device_frame(first_code);
		record_event(1'b1, first_code, 1'b0);
		code = 8'($urandom());
		send_device_frame(code); // irq1 still high, dropped
		record_event(1'b1, code, 1'b0);
		pulse_clear();
		code = 8'($urandom());
		send_device_frame(code);
		record_event(1'b1, code, 1'b0);
		pulse_clear();

		repeat (20) begin
			code = 8'($urandom());
			send_device_frame(code);
			record_event(1'b1, code, 1'b0);
			pulse_clear();
		end

		n = 0;
		while (checked_seq != check_seq && n < 10) begin
			@(posedge latch);
			n++;
		end
		if (checked_seq != check_seq) begin
			errors++;
			$display("timeout: last comparison never ran");
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- kbd_interface.f
+incdir+include
logic/kbd_pkg.sv
logic/kbd_line_if.sv
logic/kbd_line_sync.sv
logic/kbd_frame_rx.sv
logic/kbd_frame_tx.sv
logic/kbd_ctrl.sv
logic/kbd_interface.sv
tests/tb_clock_gen.sv
tests/kbd_interface_sva.sv
tests/tb_kbd_interface.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f kbd_interface.f --top-module tb_kbd_interface

out=$(./obj_dir/Vtb_kbd_interface 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TEST PASSED"; then
	exit 0
fi
exit 1
